/* Bender.yml */
package:
  name: vdec_hs

sources:
  - vdec_hs_pkg.sv
  - vdec_hs_job_decode.sv
  - vdec_hs_ctrl.sv
  - vdec_hs_crc_frame.sv
  - vdec_hs_crc16.sv
  - vdec_hs.sv
  - target: test
    files:
      - tb_vdec_hs.sv

/* tb_vdec_hs.sv */
module tb_vdec_hs;

    localparam int MAX_CYCLES = 20 * 70;    // 20 jobs, 70 cycles worst case each
    localparam int K_P1   = 0;
    localparam int K_P2   = 1;
    localparam int K_NS1  = 2;
    localparam int K_NS2  = 3;
    localparam int K_AGCH = 4;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start_part1;
    logic        start_part2;
    logic        start_ns_part1;
    logic        start_ns_part2;
    logic        start_agch;
    logic        hsscch_ca_sel;
    logic        hsscch_pp_sel;
    logic [1:0]  hsscch_ch_sel;
    logic        hsscch_uemask2_sel;
    logic [15:0] hsscch_uemask;
    logic        ns_hsscch_sel;
    logic [15:0] ns_hsscch_uemask;
    logic        agch_sel;
    logic [15:0] agch_uemask1;
    logic [15:0] agch_uemask2;
    logic        busy;
    logic        done;
    logic        done_hsscch_part1;
    logic        done_hsscch_part2;
    logic        done_ns_hsscch_part1;
    logic        done_ns_hsscch_part2;
    logic        done_agch;
    logic        agch_crc1;
    logic        agch_crc2;
    logic        vdec_crc;
    logic [31:0] vdec_output;
    logic        dec_start;
    logic [9:0]  dec_base;
    logic [5:0]  dec_len;
    logic        dec_done;
    logic [28:0] dec_bits;

    logic [31:0] lfsr = 32'h048b1422;
    logic [28:0] model_bits;                // what the core model returns next
    int          dec_starts = 0;
    int          cycles = 0;
    int          checks = 0;
    int          val_errors = 0;
    int          prop_errors = 0;
    string       test_name = "reset";

    vdec_hs dut_i (.*);

    always #4 clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [36:0] rand_bits(input int n);
        logic [36:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[35:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // remainder over the low len bits, msb first, zero start
    function automatic logic [15:0] crc16_ref(input logic [36:0] w, input int len);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = len - 1; i >= 0; i--) begin
            fb = r[15] ^ w[i];
            r  = {r[14:0], 1'b0} ^ (fb ? vdec_hs_pkg::CRC16_POLY : 16'h0000);
        end
        return r;
    endfunction

    // random message with its crc appended, remainder zero
    function automatic logic [36:0] valid_frame(input int len);
        logic [36:0] msg;
        msg = rand_bits(len - 16);
        return (msg << 16) | 37'(crc16_ref(msg, len - 16));
    endfunction

    function automatic logic [28:0] part2_bits(input logic [36:0] w, input logic [15:0] mask);
        logic [28:0] b;
        for (int i = 0; i < 16; i++) begin
            b[13+i] = w[36-i] ^ mask[15-i];
        end
        b[12:0] = w[20:8];
        return b;
    endfunction

    function automatic logic [28:0] agch_bits(input logic [36:0] w, input logic [15:0] mask);
        logic [28:0] b;
        b = 29'(rand_bits(29));             // bits above 21 are don't care
        for (int i = 0; i < 16; i++) begin
            b[6+i] = w[21-i] ^ mask[15-i];
        end
        b[5:0] = w[5:0];
        return b;
    endfunction

    function automatic logic [31:0] reversed(input logic [28:0] b);
        logic [28:0] r;
        r = {<<{b}};
        return {r, 3'b000};
    endfunction

    function automatic logic [9:0] hs_base_ref(input logic [3:0] sel);
        if (sel < 4'd8) begin
            return 10'(sel) * 10'h020;
        end else begin
            return 10'h160 + 10'(sel - 4'd8) * 10'h020;
        end
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            val_errors++;
            $display("Error %s: %s expected %h, got %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, val_errors, prop_errors);
    endtask

    // ----------------------------------------
    // protocol assertions
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $onehot({done_hsscch_part1, done_hsscch_part2, done_ns_hsscch_part1,
                          done_ns_hsscch_part2, done_agch}))
        else begin
            prop_errors++;
            $display("done pulsed without exactly one done_* output at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else begin
            prop_errors++;
            $display("busy still high while done pulsed at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) dec_start |-> busy)
        else begin
            prop_errors++;
            $display("dec_start pulsed while not busy at %0t", $time);
        end

    // ----------------------------------------
    // viterbi core model and watchdog
    // ----------------------------------------
    always @(posedge clk) begin
        if (dec_start) begin
            dec_starts <= dec_starts + 1;
        end
    end

    initial begin : dec_model
        int delay;
        dec_done = 1'b0;
        dec_bits = '0;
        forever begin
            @(posedge clk);
            if (dec_start) begin
                delay = 1 + int'(rand_bits(3));     // 1 to 8 cycles
                repeat (delay - 1) @(posedge clk);
                @(negedge clk);
                dec_bits = model_bits;              // held until the next job
                dec_done = 1'b1;
                @(negedge clk);
                dec_done = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, no done after %0d cycles in test %s", cycles, test_name);
            report_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    // one job from start to done, checks on the falling edge
    task automatic run_job(input int kind, input logic [9:0] exp_base, input logic [28:0] bits,
                           input logic poke, input logic exp_crc, input logic exp_a1,
                           input logic exp_a2);
        logic [5:0] exp_len;
        int         starts_before;
        case (kind)
            K_P1, K_NS1: exp_len = vdec_hs_pkg::PART1_BLK_LEN;
            K_P2, K_NS2: exp_len = vdec_hs_pkg::PART2_BLK_LEN;
            default:     exp_len = vdec_hs_pkg::AGCH_BLK_LEN;
        endcase
        model_bits    = bits;
        starts_before = dec_starts;
        case (kind)
            K_P1:    start_part1    = 1'b1;
            K_P2:    start_part2    = 1'b1;
            K_NS1:   start_ns_part1 = 1'b1;
            K_NS2:   start_ns_part2 = 1'b1;
            default: start_agch     = 1'b1;
        endcase
        @(negedge clk);
        start_part1    = poke;              // second start while busy
        start_part2    = 1'b0;
        start_ns_part1 = 1'b0;
        start_ns_part2 = 1'b0;
        start_agch     = 1'b0;
        check_val("busy", 1, busy);
        check_val("dec_base", exp_base, dec_base);
        check_val("dec_len", exp_len, dec_len);
        @(negedge clk);
        start_part1 = 1'b0;
        if (kind == K_AGCH) begin
            check_val("agch_crc1 cleared", 0, agch_crc1);
        end
        while (!done) begin
            @(negedge clk);
        end
        check_val("done outputs", 32'(1 << kind), {done_agch, done_ns_hsscch_part2,
                  done_ns_hsscch_part1, done_hsscch_part2, done_hsscch_part1});
        check_val("dec_start count", 1, dec_starts - starts_before);
        check_val("vdec_output", reversed(bits), vdec_output);
        if (kind == K_P2 || kind == K_NS2 || kind == K_AGCH) begin
            check_val("vdec_crc", exp_crc, vdec_crc);
        end
        if (kind == K_AGCH) begin
            check_val("agch_crc1", exp_a1, agch_crc1);
            check_val("agch_crc2", exp_a2, agch_crc2);
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [3:0]  sels [4];
        logic [3:0]  sel;
        logic [36:0] w;
        logic [28:0] b;
        sels               = '{4'd3, 4'd9, 4'd14, 4'd6};
        rst_n              = 1'b0;
        start_part1        = 1'b0;
        start_part2        = 1'b0;
        start_ns_part1     = 1'b0;
        start_ns_part2     = 1'b0;
        start_agch         = 1'b0;
        hsscch_ca_sel      = 1'b0;
        hsscch_pp_sel      = 1'b0;
        hsscch_ch_sel      = 2'd0;
        hsscch_uemask2_sel = 1'b0;
        hsscch_uemask      = 16'ha5c3;
        ns_hsscch_sel      = 1'b0;
        ns_hsscch_uemask   = 16'h3c5a;
        agch_sel           = 1'b0;
        agch_uemask1       = 16'h1234;
        agch_uemask2       = 16'hbeef;
        model_bits         = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("outputs after reset", 0, {busy, done, done_hsscch_part1, done_hsscch_part2,
                  done_ns_hsscch_part1, done_ns_hsscch_part2, done_agch, dec_start,
                  agch_crc1, agch_crc2, vdec_crc});

        test_name = "hs_part1";
        for (int k = 0; k < 4; k++) begin
            {hsscch_ca_sel, hsscch_pp_sel, hsscch_ch_sel} = sels[k];
            run_job(K_P1, hs_base_ref(sels[k]), 29'(rand_bits(29)), k == 1, 0, 0, 0);
        end

        // part 2 on ca 1, pp 0, ch 2
        test_name = "hs_part2";
        sel = 4'b1010;
        {hsscch_ca_sel, hsscch_pp_sel, hsscch_ch_sel} = sel;
        w = valid_frame(37);
        b = part2_bits(w, hsscch_uemask);
        run_job(K_P1, hs_base_ref(sel), {21'(rand_bits(21)), w[7:0]}, 0, 0, 0, 0);
        run_job(K_P2, hs_base_ref(sel) + 10'h00a, b, 0, 1, 0, 0);
        test_name = "hs_part2_flip";
        run_job(K_P2, hs_base_ref(sel) + 10'h00a, b ^ (29'h1 << 17), 0, 0, 0, 0);
        test_name = "hs_part2_stale";
        run_job(K_P1, hs_base_ref(sel), {21'(rand_bits(21)), ~w[7:0]}, 0, 0, 0, 0);
        run_job(K_P2, hs_base_ref(sel) + 10'h00a, b, 0, 0, 0, 0);

        test_name = "ns_part2";
        ns_hsscch_sel = 1'b1;
        w = valid_frame(37);
        run_job(K_NS1, vdec_hs_pkg::NS_BASE1, {21'(rand_bits(21)), w[7:0]}, 0, 0, 0, 0);
        run_job(K_NS2, vdec_hs_pkg::NS_BASE1 + 10'h00a, part2_bits(w, ns_hsscch_uemask),
                0, 1, 0, 0);

        test_name = "agch_mask2";
        w = valid_frame(22);
        run_job(K_AGCH, vdec_hs_pkg::AGCH_BASE0, agch_bits(w, agch_uemask2), 0, 1, 0, 1);
        test_name = "agch_mask1";
        agch_sel = 1'b1;
        w = valid_frame(22);
        run_job(K_AGCH, vdec_hs_pkg::AGCH_BASE1, agch_bits(w, agch_uemask1), 0, 0, 1, 0);
        // agch_crc1 is high from the last job, so its clear shows here
        test_name = "agch_clear";
        w = valid_frame(22);
        run_job(K_AGCH, vdec_hs_pkg::AGCH_BASE1, agch_bits(w, agch_uemask2), 0, 1, 0, 1);

        repeat (2) @(negedge clk);
        report_counts();
        if (val_errors == 0 && prop_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vdec_hs.f */
vdec_hs_pkg.sv
vdec_hs_job_decode.sv
vdec_hs_ctrl.sv
vdec_hs_crc_frame.sv
vdec_hs_crc16.sv
vdec_hs.sv
tb_vdec_hs.sv

/* vdec_hs.sv */
module vdec_hs (
    input  logic                   clk,
    input  logic                   rst_n,
    // host starts
    input  logic                   start_part1,
    input  logic                   start_part2,
    input  logic                   start_ns_part1,
    input  logic                   start_ns_part2,
    input  logic                   start_agch,
    // selects and masks
    input  logic                   hsscch_ca_sel,
    input  logic                   hsscch_pp_sel,
    input  logic [1:0]             hsscch_ch_sel,
    input  logic                   hsscch_uemask2_sel,
    input  vdec_hs_pkg::ue_mask_t  hsscch_uemask,
    input  logic                   ns_hsscch_sel,
    input  vdec_hs_pkg::ue_mask_t  ns_hsscch_uemask,
    input  logic                   agch_sel,
    input  vdec_hs_pkg::ue_mask_t  agch_uemask1,
    input  vdec_hs_pkg::ue_mask_t  agch_uemask2,
    // status and results
    output logic                   busy,
    output logic                   done,
    output logic                   done_hsscch_part1,
    output logic                   done_hsscch_part2,
    output logic                   done_ns_hsscch_part1,
    output logic                   done_ns_hsscch_part2,
    output logic                   done_agch,
    output logic                   agch_crc1,
    output logic                   agch_crc2,
    output logic                   vdec_crc,
    output logic [31:0]            vdec_output,
    // external viterbi core
    output logic                   dec_start,
    output vdec_hs_pkg::sys_addr_t dec_base,
    output vdec_hs_pkg::blk_len_t  dec_len,
    input  logic                   dec_done,
    input  vdec_hs_pkg::dec_bits_t dec_bits
);

    logic                     accept;
    vdec_hs_pkg::hs_mode_e    hs_mode;
    logic                     ns_type;
    logic                     crc_start;
    logic                     crc_done;
    logic                     crc_match;
    logic                     agch_pass;
    vdec_hs_pkg::check_bits_t check_bits;
    vdec_hs_pkg::blk_len_t    check_len;

    vdec_hs_job_decode job_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .busy           (busy),
        .start_part1    (start_part1),
        .start_part2    (start_part2),
        .start_ns_part1 (start_ns_part1),
        .start_ns_part2 (start_ns_part2),
        .start_agch     (start_agch),
        .hsscch_ca_sel  (hsscch_ca_sel),
        .hsscch_pp_sel  (hsscch_pp_sel),
        .hsscch_ch_sel  (hsscch_ch_sel),
        .ns_hsscch_sel  (ns_hsscch_sel),
        .agch_sel       (agch_sel),
        .accept         (accept),
        .hs_mode        (hs_mode),
        .ns_type        (ns_type),
        .dec_base       (dec_base),
        .dec_len        (dec_len)
    );

    vdec_hs_ctrl ctrl_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .accept               (accept),
        .hs_mode              (hs_mode),
        .ns_type              (ns_type),
        .dec_done             (dec_done),
        .crc_done             (crc_done),
        .crc_match            (crc_match),
        .busy                 (busy),
        .dec_start            (dec_start),
        .crc_start            (crc_start),
        .agch_pass            (agch_pass),
        .done                 (done),
        .done_hsscch_part1    (done_hsscch_part1),
        .done_hsscch_part2    (done_hsscch_part2),
        .done_ns_hsscch_part1 (done_ns_hsscch_part1),
        .done_ns_hsscch_part2 (done_ns_hsscch_part2),
        .done_agch            (done_agch),
        .agch_crc1            (agch_crc1),
        .agch_crc2            (agch_crc2),
        .vdec_crc             (vdec_crc)
    );

    vdec_hs_crc_frame frame_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .dec_done           (dec_done),
        .hs_mode            (hs_mode),
        .ns_type            (ns_type),
        .agch_pass          (agch_pass),
        .hsscch_ca_sel      (hsscch_ca_sel),
        .hsscch_ch_sel      (hsscch_ch_sel),
        .hsscch_uemask2_sel (hsscch_uemask2_sel),
        .dec_bits           (dec_bits),
        .hsscch_uemask      (hsscch_uemask),
        .ns_hsscch_uemask   (ns_hsscch_uemask),
        .agch_uemask1       (agch_uemask1),
        .agch_uemask2       (agch_uemask2),
        .check_bits         (check_bits),
        .check_len          (check_len)
    );

    vdec_hs_crc16 crc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (crc_start),
        .check_bits (check_bits),
        .check_len  (check_len),
        .done       (crc_done),
        .match      (crc_match)
    );

    // first decoded bit lands on bit 31
    always_comb begin
        vdec_output = '0;
        for (int i = 0; i < 29; i++) begin
            vdec_output[31-i] = dec_bits[i];
        end
    end

endmodule

/* vdec_hs_crc16.sv */
module vdec_hs_crc16 (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  vdec_hs_pkg::check_bits_t check_bits,
    input  vdec_hs_pkg::blk_len_t    check_len,
    output logic                     done,
    output logic                     match
);

    logic [15:0]           crc_q;
    logic [15:0]           crc_nxt;
    vdec_hs_pkg::blk_len_t cnt_q;       // bits left, also the bit pointer
    logic                  run_q;
    logic                  fb;

    // msb first, check word held stable by the controller during a pass
    assign fb      = crc_q[15] ^ check_bits[cnt_q - 6'd1];
    assign crc_nxt = {crc_q[14:0], 1'b0} ^ (fb ? vdec_hs_pkg::CRC16_POLY : 16'h0000);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= '0;
            cnt_q <= '0;
            run_q <= 1'b0;
            done  <= 1'b0;
            match <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                crc_q <= '0;
                cnt_q <= check_len;
                run_q <= 1'b1;
            end else if (run_q) begin
                crc_q <= crc_nxt;
                cnt_q <= cnt_q - 6'd1;
                if (cnt_q == 6'd1) begin            // last bit
                    run_q <= 1'b0;
                    done  <= 1'b1;
                    match <= (crc_nxt == 16'h0000);
                end
            end
        end
    end

endmodule

/* vdec_hs_crc_frame.sv */
module vdec_hs_crc_frame (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dec_done,
    input  vdec_hs_pkg::hs_mode_e    hs_mode,
    input  logic                     ns_type,
    input  logic                     agch_pass,
    input  logic                     hsscch_ca_sel,
    input  logic [1:0]               hsscch_ch_sel,
    input  logic                     hsscch_uemask2_sel,
    input  vdec_hs_pkg::dec_bits_t   dec_bits,
    input  vdec_hs_pkg::ue_mask_t    hsscch_uemask,
    input  vdec_hs_pkg::ue_mask_t    ns_hsscch_uemask,
    input  vdec_hs_pkg::ue_mask_t    agch_uemask1,
    input  vdec_hs_pkg::ue_mask_t    agch_uemask2,
    output vdec_hs_pkg::check_bits_t check_bits,
    output vdec_hs_pkg::blk_len_t    check_len
);

    localparam int NUM_SLOTS = 10;
    localparam logic [3:0] SLOT_UEMASK2 = 4'd8;
    localparam logic [3:0] SLOT_NS      = 4'd9;

    vdec_hs_pkg::part1_info_t slots [NUM_SLOTS];
    logic [3:0]               slot_idx;
    vdec_hs_pkg::ue_mask_t    hs_mask;
    vdec_hs_pkg::ue_mask_t    agch_mask;

    // ----------------------------------------
    // part-1 info store
    // ----------------------------------------
    // same index for the write after part 1 and the read during part 2
    always_comb begin
        if (ns_type) begin
            slot_idx = SLOT_NS;
        end else if (hsscch_uemask2_sel) begin
            slot_idx = SLOT_UEMASK2;
        end else begin
            slot_idx = {1'b0, hsscch_ca_sel, hsscch_ch_sel};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else if (dec_done && hs_mode == vdec_hs_pkg::mode_part1) begin
            slots[slot_idx] <= dec_bits[7:0];
        end
    end

    // ----------------------------------------
    // check word assembly
    // ----------------------------------------
    assign hs_mask   = ns_type ? ns_hsscch_uemask : hsscch_uemask;
    assign agch_mask = agch_pass ? agch_uemask2 : agch_uemask1;

    always_comb begin
        check_bits = '0;
        check_len  = '0;                            // part 1 is not checked
        case (hs_mode)
            vdec_hs_pkg::mode_part2: begin
                for (int i = 0; i < 16; i++) begin  // masked parity, first bit on msb
                    check_bits[36-i] = dec_bits[13+i] ^ hs_mask[15-i];
                end
                check_bits[20:8] = dec_bits[12:0];
                check_bits[7:0]  = slots[slot_idx];
                check_len        = vdec_hs_pkg::PART2_CHECK_LEN;
            end
            vdec_hs_pkg::mode_agch: begin
                for (int i = 0; i < 16; i++) begin
                    check_bits[21-i] = dec_bits[6+i] ^ agch_mask[15-i];
                end
                check_bits[5:0] = dec_bits[5:0];
                check_len       = vdec_hs_pkg::AGCH_CHECK_LEN;
            end
            default: begin
            end
        endcase
    end

endmodule

/* vdec_hs_ctrl.sv */
module vdec_hs_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  accept,
    input  vdec_hs_pkg::hs_mode_e hs_mode,
    input  logic                  ns_type,
    input  logic                  dec_done,
    input  logic                  crc_done,
    input  logic                  crc_match,
    output logic                  busy,
    output logic                  dec_start,
    output logic                  crc_start,
    output logic                  agch_pass,
    output logic                  done,
    output logic                  done_hsscch_part1,
    output logic                  done_hsscch_part2,
    output logic                  done_ns_hsscch_part1,
    output logic                  done_ns_hsscch_part2,
    output logic                  done_agch,
    output logic                  agch_crc1,
    output logic                  agch_crc2,
    output logic                  vdec_crc
);

    typedef enum logic [1:0] {idle, decode, check, finish} state_e;

    state_e state;
    logic   is_agch;

    assign is_agch = (hs_mode == vdec_hs_pkg::mode_agch);

    // ----------------------------------------
    // sequencing
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            dec_start <= 1'b0;
            crc_start <= 1'b0;
            agch_pass <= 1'b0;
            agch_crc1 <= 1'b0;
            agch_crc2 <= 1'b0;
            vdec_crc  <= 1'b0;
        end else begin
            dec_start <= 1'b0;
            crc_start <= 1'b0;
            case (state)
                decode: begin
                    if (dec_start && is_agch) begin     // fresh agch job
                        agch_crc1 <= 1'b0;
                        agch_crc2 <= 1'b0;
                    end
                    if (dec_done) begin
                        if (hs_mode == vdec_hs_pkg::mode_part1) begin
                            state     <= finish;        // no crc on part 1
                        end else begin
                            state     <= check;
                            crc_start <= 1'b1;
                        end
                    end
                end
                check: begin
                    if (crc_done) begin
                        vdec_crc <= crc_match;
                        if (is_agch && !agch_pass) begin
                            agch_crc1 <= crc_match;
                            agch_pass <= 1'b1;          // rerun with uemask2
                            crc_start <= 1'b1;
                        end else begin
                            if (is_agch) begin
                                agch_crc2 <= crc_match;
                            end
                            state <= finish;
                        end
                    end
                end
                default: begin                          // idle or finish
                    state <= idle;
                    if (accept) begin
                        state     <= decode;
                        dec_start <= 1'b1;
                        agch_pass <= 1'b0;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // status and done split
    // ----------------------------------------
    assign busy = (state == decode) || (state == check);
    assign done = (state == finish);

    assign done_hsscch_part1    = done & ~ns_type & (hs_mode == vdec_hs_pkg::mode_part1);
    assign done_hsscch_part2    = done & ~ns_type & (hs_mode == vdec_hs_pkg::mode_part2);
    assign done_ns_hsscch_part1 = done &  ns_type & (hs_mode == vdec_hs_pkg::mode_part1);
    assign done_ns_hsscch_part2 = done &  ns_type & (hs_mode == vdec_hs_pkg::mode_part2);
    assign done_agch            = done & is_agch;

endmodule

/* vdec_hs_job_decode.sv */
module vdec_hs_job_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   busy,
    input  logic                   start_part1,
    input  logic                   start_part2,
    input  logic                   start_ns_part1,
    input  logic                   start_ns_part2,
    input  logic                   start_agch,
    input  logic                   hsscch_ca_sel,
    input  logic                   hsscch_pp_sel,
    input  logic [1:0]             hsscch_ch_sel,
    input  logic                   ns_hsscch_sel,
    input  logic                   agch_sel,
    output logic                   accept,
    output vdec_hs_pkg::hs_mode_e  hs_mode,
    output logic                   ns_type,
    output vdec_hs_pkg::sys_addr_t dec_base,
    output vdec_hs_pkg::blk_len_t  dec_len
);

    vdec_hs_pkg::hs_mode_e  mode_nxt;
    logic                   ns_nxt;
    logic [3:0]             hs_sel;
    vdec_hs_pkg::sys_addr_t hs_base;
    vdec_hs_pkg::sys_addr_t base_nxt;
    vdec_hs_pkg::blk_len_t  len_nxt;

    assign accept = ~busy & (start_part1 | start_part2 | start_ns_part1 |
                             start_ns_part2 | start_agch);

    // upper half of the select range sits above the agch/ns area
    assign hs_sel  = {hsscch_ca_sel, hsscch_pp_sel, hsscch_ch_sel};
    assign hs_base = (hs_sel[3] ? vdec_hs_pkg::HS_BASE_HI : vdec_hs_pkg::HS_BASE_LO)
                   + vdec_hs_pkg::sys_addr_t'(hs_sel[2:0]) * vdec_hs_pkg::HS_BASE_STEP;

    always_comb begin
        mode_nxt = vdec_hs_pkg::mode_part1;     // fixed priority order
        ns_nxt   = 1'b0;
        if (start_part1) begin
            mode_nxt = vdec_hs_pkg::mode_part1;
        end else if (start_part2) begin
            mode_nxt = vdec_hs_pkg::mode_part2;
        end else if (start_ns_part1) begin
            ns_nxt   = 1'b1;
        end else if (start_ns_part2) begin
            mode_nxt = vdec_hs_pkg::mode_part2;
            ns_nxt   = 1'b1;
        end else begin
            mode_nxt = vdec_hs_pkg::mode_agch;
        end
    end

    always_comb begin
        case (mode_nxt)
            vdec_hs_pkg::mode_agch: begin
                base_nxt = agch_sel ? vdec_hs_pkg::AGCH_BASE1 : vdec_hs_pkg::AGCH_BASE0;
                len_nxt  = vdec_hs_pkg::AGCH_BLK_LEN;
            end
            vdec_hs_pkg::mode_part2: begin
                base_nxt = (ns_nxt ? (ns_hsscch_sel ? vdec_hs_pkg::NS_BASE1
                                                    : vdec_hs_pkg::NS_BASE0)
                                   : hs_base) + vdec_hs_pkg::PART2_OFFSET;
                len_nxt  = vdec_hs_pkg::PART2_BLK_LEN;
            end
            default: begin
                base_nxt = ns_nxt ? (ns_hsscch_sel ? vdec_hs_pkg::NS_BASE1
                                                   : vdec_hs_pkg::NS_BASE0)
                                  : hs_base;
                len_nxt  = vdec_hs_pkg::PART1_BLK_LEN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_mode  <= vdec_hs_pkg::mode_part1;
            ns_type  <= 1'b0;
            dec_base <= '0;
            dec_len  <= '0;
        end else if (accept) begin
            hs_mode  <= mode_nxt;
            ns_type  <= ns_nxt;
            dec_base <= base_nxt;
            dec_len  <= len_nxt;
        end
    end

endmodule

/* vdec_hs_pkg.sv */
package vdec_hs_pkg;

    // ----------------------------------------
    // job format and data widths
    // ----------------------------------------
    typedef enum logic [1:0] {
        mode_part1,     // hs-scch part 1, serving or non-serving
        mode_part2,     // hs-scch part 2, serving or non-serving
        mode_agch       // e-agch
    } hs_mode_e;

    typedef logic [9:0]  sys_addr_t;    // soft-symbol word address
    typedef logic [5:0]  blk_len_t;     // block length incl. tail, or crc length
    typedef logic [28:0] dec_bits_t;    // bit 0 is first decoded bit
    typedef logic [15:0] ue_mask_t;
    typedef logic [7:0]  part1_info_t;
    typedef logic [36:0] check_bits_t;

    // ----------------------------------------
    // format lengths
    // ----------------------------------------
    localparam blk_len_t PART1_BLK_LEN   = 6'd15;  // 8 info + 7 tail
    localparam blk_len_t PART2_BLK_LEN   = 6'd36;  // 29 + 7
    localparam blk_len_t AGCH_BLK_LEN    = 6'd29;  // 22 + 7

    localparam blk_len_t PART2_CHECK_LEN = 6'd37;  // 21 info + 16 parity
    localparam blk_len_t AGCH_CHECK_LEN  = 6'd22;  // 6 info + 16 parity

    // x^16 + x^12 + x^5 + 1
    localparam logic [15:0] CRC16_POLY = 16'h1021;

    // ----------------------------------------
    // soft-symbol base addresses
    // ----------------------------------------
    localparam sys_addr_t HS_BASE_LO   = 10'h000;  // sel 0..7
    localparam sys_addr_t HS_BASE_HI   = 10'h160;  // sel 8..15
    localparam sys_addr_t HS_BASE_STEP = 10'h020;

    // part 2 symbols follow part 1 in the same slot
    localparam sys_addr_t PART2_OFFSET = 10'h00A;

    localparam sys_addr_t NS_BASE0     = 10'h120;
    localparam sys_addr_t NS_BASE1     = 10'h140;

    localparam sys_addr_t AGCH_BASE0   = 10'h100;
    localparam sys_addr_t AGCH_BASE1   = 10'h110;

endpackage
